// File: verilog/mvd_settings.svh
/* Widths and limits of the MVD stage. MV components are signed two's complement,
   and an MVD component is one bit wider than an MV component. */
`ifndef MVD_SETTINGS_SVH
`define MVD_SETTINGS_SVH

`define MVD_MV_W        10  // one mv component
`define MVD_MVD_W       11  // difference of two mv components
`define MVD_BLK_ADDR_W  6   // {y[2:0], x[2:0]} of an 8x8 block
`define MVD_PART_W      42  // 2 bits for each of cu 0..20
`define MVD_CU_IDX_W    7   // cu index 0..84
`define MVD_COST_W      5   // bit cost of one mvd component
`define MVD_LAST_CU     84  // last 8x8 cu in z-order

`endif

// File: verilog/mvd_pkg.sv
/* Types shared by the MVD stage. Struct fields are listed MSB first,
   so mv_t keeps x in the upper half. */
`default_nettype none

`include "mvd_settings.svh"

package mvd_pkg;

    typedef enum logic [1:0] {
        IDLE,
        SPLIT,
        CU_RUN,
        DONE
    } lcu_state_e;

    typedef enum logic [1:0] {
        PART_2NX2N = 2'd0,
        PART_2NXN  = 2'd1,  // two PUs stacked
        PART_NX2N  = 2'd2,  // two PUs side by side
        PART_SPLIT = 2'd3
    } part_e;

    typedef enum logic [1:0] {
        PH_CUR,
        PH_A,
        PH_B,
        PH_SEL
    } pu_phase_e;

    typedef struct packed {
        logic signed [`MVD_MV_W-1:0] x;
        logic signed [`MVD_MV_W-1:0] y;
    } mv_t;

    typedef struct packed {
        logic                       en;
        logic [`MVD_BLK_ADDR_W-1:0] addr;
    } mv_rd_t;

    typedef struct packed {
        logic [`MVD_CU_IDX_W-1:0] idx;
        logic [1:0]               depth;  // 0 is 64x64, 3 is 8x8
        part_e                    part;
    } cu_info_t;

    typedef struct packed {
        logic a_avail;
        logic b_avail;
    } nb_avail_t;

    typedef struct packed {
        logic                         valid;
        logic [`MVD_BLK_ADDR_W-1:0]   addr;  // top-left block of the PU
        logic                         mvp_idx;
        logic signed [`MVD_MVD_W-1:0] x;
        logic signed [`MVD_MVD_W-1:0] y;
    } mvd_out_t;

endpackage

`default_nettype wire

// File: verilog/mvd_lcu_fsm.sv
/* Walks the CU quadtree of one LCU in z-order. part_i must stay stable while
   start_req_i is high; done_ack_o rises in the PH_SEL cycle of the last PU. */
`default_nettype none

`include "mvd_settings.svh"

module mvd_lcu_fsm (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    start_req_i,
    input  wire logic [`MVD_PART_W-1:0]  part_i,
    input  wire logic                    cu_end_i,
    output mvd_pkg::cu_info_t            cu_info_o,
    output logic                         cu_go_o,
    output logic                         done_ack_o
);
    import mvd_pkg::*;

    localparam int FIRST_D3 = `MVD_LAST_CU - 63;  // first 8x8 cu

    lcu_state_e               state_q;
    lcu_state_e               state_d;
    logic [`MVD_CU_IDX_W-1:0] idx_q;
    logic [`MVD_CU_IDX_W-1:0] idx_d;
    logic [1:0]               depth;
    part_e                    part;
    logic [63:0]              part_ext;
    logic                     walk_done;
    logic [`MVD_CU_IDX_W-1:0] walk_next;

    // next cu in z-order after idx, climbing past last siblings; MSB set when none
    function automatic logic [`MVD_CU_IDX_W:0] next_cu(input logic [`MVD_CU_IDX_W-1:0] idx);
        logic [`MVD_CU_IDX_W-1:0] node;
        logic [`MVD_CU_IDX_W-1:0] offs;
        logic [`MVD_CU_IDX_W-1:0] nxt;
        logic                     found;
        node  = idx;
        offs  = '0;
        nxt   = '0;
        found = 1'b0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            if (!found && node != '0) begin
                offs = node - 1'b1;
                if (offs[1:0] != 2'd3) begin
                    nxt   = node + 1'b1;  // next sibling
                    found = 1'b1;
                end else begin
                    node = offs >> 2;  // parent
                end
            end
        end
        return {!found, nxt};
    endfunction

    always_comb begin
        if (idx_q == '0) begin
            depth = 2'd0;
        end else if (idx_q < 7'd5) begin
            depth = 2'd1;
        end else if (idx_q < FIRST_D3) begin
            depth = 2'd2;
        end else begin
            depth = 2'd3;
        end
    end

    // only cu 0..20 have a field, 8x8 cus are always 2Nx2N
    assign part_ext = {{(64 - `MVD_PART_W){1'b0}}, part_i};
    assign part     = (depth == 2'd3) ? PART_2NX2N
                                      : part_e'(part_ext[{idx_q[4:0], 1'b0} +: 2]);

    assign {walk_done, walk_next} = next_cu(idx_q);

    assign cu_info_o  = '{idx: idx_q, depth: depth, part: part};
    assign cu_go_o    = (state_q == SPLIT) && (part != PART_SPLIT);
    assign done_ack_o = (state_q == DONE) || (state_q == CU_RUN && cu_end_i && walk_done);

    always_comb begin
        state_d = state_q;
        idx_d   = idx_q;
        case (state_q)
            IDLE: begin
                if (start_req_i) begin
                    state_d = SPLIT;
                    idx_d   = '0;
                end
            end
            SPLIT: begin
                if (part == PART_SPLIT) begin
                    idx_d = {idx_q[4:0], 2'b00} + 1'b1;  // first child 4i+1
                end else begin
                    state_d = CU_RUN;
                end
            end
            CU_RUN: begin
                if (cu_end_i) begin
                    if (walk_done) begin
                        state_d = DONE;
                    end else begin
                        state_d = SPLIT;
                        idx_d   = walk_next;
                    end
                end
            end
            DONE: begin
                if (!start_req_i) state_d = IDLE;  // wait for req to drop
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            idx_q   <= '0;
        end else begin
            state_q <= state_d;
            idx_q   <= idx_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mvd_pu_timer.sv
/* Four cycles per PU, one or two PUs per CU. Between CUs the phase rests at PH_SEL
   with no PU in flight, so consumers must not treat PH_SEL alone as a PU. */
`default_nettype none

module mvd_pu_timer (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              cu_go_i,
    input  wire mvd_pkg::cu_info_t cu_info_i,
    output mvd_pkg::pu_phase_e     phase_o,
    output logic                   pu_idx_o,
    output logic                   cu_end_o
);
    import mvd_pkg::*;

    pu_phase_e phase_q;
    logic      run_q;
    logic      pu_idx_q;
    logic      last_pu;

    assign last_pu = pu_idx_q ||
                     !(cu_info_i.part == PART_2NXN || cu_info_i.part == PART_NX2N);

    assign phase_o  = phase_q;
    assign pu_idx_o = pu_idx_q;
    assign cu_end_o = run_q && (phase_q == PH_SEL) && last_pu;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q    <= 1'b0;
            phase_q  <= PH_SEL;  // park
            pu_idx_q <= 1'b0;
        end else if (cu_go_i) begin
            run_q    <= 1'b1;
            phase_q  <= PH_CUR;
            pu_idx_q <= 1'b0;
        end else if (run_q) begin
            case (phase_q)
                PH_CUR: phase_q <= PH_A;
                PH_A:   phase_q <= PH_B;
                PH_B:   phase_q <= PH_SEL;
                default: begin
                    if (last_pu) begin
                        run_q <= 1'b0;  // stay parked in PH_SEL
                    end else begin
                        phase_q  <= PH_CUR;
                        pu_idx_q <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/mvd_pu_geom.sv
/* PU placement inside the LCU and the MV memory read port. Neighbours outside
   the LCU count as unavailable; the read data comes back one cycle later. */
`default_nettype none

`include "mvd_settings.svh"

module mvd_pu_geom (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire mvd_pkg::cu_info_t            cu_info_i,
    input  wire mvd_pkg::pu_phase_e           phase_i,
    input  wire logic                         pu_idx_i,
    output mvd_pkg::mv_rd_t                   mv_rd_o,
    output mvd_pkg::nb_avail_t                avail_o,
    output logic [`MVD_BLK_ADDR_W-1:0]        pu_addr_o
);
    import mvd_pkg::*;

    localparam int FIRST_D3 = `MVD_LAST_CU - 63;

    logic [`MVD_CU_IDX_W-1:0]   off_d1;
    logic [`MVD_CU_IDX_W-1:0]   off_d2;
    logic [`MVD_CU_IDX_W-1:0]   off_d3;
    logic [5:0]                 zb;  // z-order index of the cu's first 8x8 block
    logic [2:0]                 half;
    logic [2:0]                 cu_x;
    logic [2:0]                 cu_y;
    logic [2:0]                 pu_x;
    logic [2:0]                 pu_y;
    logic [`MVD_BLK_ADDR_W-1:0] cur_addr;
    logic [`MVD_BLK_ADDR_W-1:0] a_addr;
    logic [`MVD_BLK_ADDR_W-1:0] b_addr;
    nb_avail_t                  avail;

    assign off_d1 = cu_info_i.idx - 7'd1;
    assign off_d2 = cu_info_i.idx - 7'd5;
    assign off_d3 = cu_info_i.idx - `MVD_CU_IDX_W'(FIRST_D3);

    always_comb begin
        case (cu_info_i.depth)
            2'd0: begin
                zb   = '0;
                half = 3'd4;
            end
            2'd1: begin
                zb   = {off_d1[1:0], 4'b0000};
                half = 3'd2;
            end
            2'd2: begin
                zb   = {off_d2[3:0], 2'b00};
                half = 3'd1;
            end
            default: begin
                zb   = off_d3[5:0];
                half = 3'd0;  // 8x8 has no second PU
            end
        endcase
    end

    // de-interleave z-order into block coordinates
    assign cu_x = {zb[4], zb[2], zb[0]};
    assign cu_y = {zb[5], zb[3], zb[1]};

    assign pu_x = cu_x + ((pu_idx_i && cu_info_i.part == PART_NX2N) ? half : 3'd0);
    assign pu_y = cu_y + ((pu_idx_i && cu_info_i.part == PART_2NXN) ? half : 3'd0);

    assign cur_addr      = {pu_y, pu_x};
    assign a_addr        = {pu_y, pu_x - 3'd1};  // left
    assign b_addr        = {pu_y - 3'd1, pu_x};  // above
    assign avail.a_avail = (pu_x != 3'd0);
    assign avail.b_avail = (pu_y != 3'd0);

    always_comb begin
        mv_rd_o.addr = cur_addr;
        case (phase_i)
            PH_CUR: mv_rd_o.en = 1'b1;
            PH_A: begin
                mv_rd_o.en   = avail.a_avail;
                mv_rd_o.addr = a_addr;
            end
            PH_B: begin
                mv_rd_o.en   = avail.b_avail;
                mv_rd_o.addr = b_addr;
            end
            default: mv_rd_o.en = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            avail_o <= '0;
        end else begin
            avail_o <= avail;
        end
    end

    always_ff @(posedge clk) begin
        pu_addr_o <= cur_addr;
    end

endmodule

`default_nettype wire

// File: verilog/mvd_pred_sel.sv
/* Two-entry MVP list and cost based choice. The output has no back-pressure,
   and mvd_o.valid lasts one cycle, in the cycle after PH_SEL. */
`default_nettype none

`include "mvd_settings.svh"

module mvd_pred_sel (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire mvd_pkg::pu_phase_e           phase_i,
    input  wire mvd_pkg::nb_avail_t           avail_i,
    input  wire logic [`MVD_BLK_ADDR_W-1:0]   pu_addr_i,
    input  wire mvd_pkg::mv_t                 mv_rdata_i,
    output mvd_pkg::mvd_out_t                 mvd_o
);
    import mvd_pkg::*;

    mv_t                          cur_q;
    mv_t                          a_q;
    mv_t                          cand0;
    logic                         two_cand;
    logic                         pick1;
    logic signed [`MVD_MVD_W-1:0] d0_x;
    logic signed [`MVD_MVD_W-1:0] d0_y;
    logic signed [`MVD_MVD_W-1:0] d1_x;
    logic signed [`MVD_MVD_W-1:0] d1_y;
    logic [`MVD_COST_W:0]         cost0;
    logic [`MVD_COST_W:0]         cost1;
    logic                         sel_armed_q;
    logic                         valid_q;
    logic [`MVD_BLK_ADDR_W-1:0]   addr_q;
    logic                         mvp_idx_q;
    logic signed [`MVD_MVD_W-1:0] mvd_x_q;
    logic signed [`MVD_MVD_W-1:0] mvd_y_q;

    function automatic logic signed [`MVD_MVD_W-1:0] mv_sub(
        input logic signed [`MVD_MV_W-1:0] a,
        input logic signed [`MVD_MV_W-1:0] b
    );
        logic signed [`MVD_MVD_W-1:0] wa;
        logic signed [`MVD_MVD_W-1:0] wb;
        wa = a;  // sign extend
        wb = b;
        return wa - wb;
    endfunction

    // 2*bitlength(|d|)+1, which gives 1 for zero
    function automatic logic [`MVD_COST_W-1:0] comp_cost(input logic signed [`MVD_MVD_W-1:0] d);
        logic [`MVD_MVD_W-1:0]  mag;
        logic [`MVD_COST_W-1:0] len;
        mag = d[`MVD_MVD_W-1] ? -d : d;
        len = '0;
        for (int i = 0; i < `MVD_MVD_W; i++) begin
            if (mag[i]) len = `MVD_COST_W'(i + 1);
        end
        return (len << 1) + 1'b1;
    endfunction

    // B arrives straight from memory in PH_SEL
    always_comb begin
        if (avail_i.a_avail) begin
            cand0 = a_q;
        end else if (avail_i.b_avail) begin
            cand0 = mv_rdata_i;
        end else begin
            cand0 = '0;  // zero predictor
        end
    end

    assign two_cand = avail_i.a_avail && avail_i.b_avail && (mv_rdata_i != a_q);

    assign d0_x = mv_sub(cur_q.x, cand0.x);
    assign d0_y = mv_sub(cur_q.y, cand0.y);
    assign d1_x = mv_sub(cur_q.x, mv_rdata_i.x);
    assign d1_y = mv_sub(cur_q.y, mv_rdata_i.y);

    assign cost0 = {1'b0, comp_cost(d0_x)} + {1'b0, comp_cost(d0_y)};
    assign cost1 = {1'b0, comp_cost(d1_x)} + {1'b0, comp_cost(d1_y)};
    assign pick1 = two_cand && (cost1 < cost0);  // ties keep index 0

    // PH_SEL only counts right after PH_B, the timer rests in PH_SEL when idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_armed_q <= 1'b0;
            valid_q     <= 1'b0;
        end else begin
            sel_armed_q <= (phase_i == PH_B);
            valid_q     <= sel_armed_q && (phase_i == PH_SEL);
        end
    end

    always_ff @(posedge clk) begin
        if (phase_i == PH_A) cur_q <= mv_rdata_i;
        if (phase_i == PH_B) a_q <= mv_rdata_i;
        if (phase_i == PH_SEL) begin
            addr_q    <= pu_addr_i;
            mvp_idx_q <= pick1;
            mvd_x_q   <= pick1 ? d1_x : d0_x;
            mvd_y_q   <= pick1 ? d1_y : d0_y;
        end
    end

    assign mvd_o.valid   = valid_q;
    assign mvd_o.addr    = addr_q;
    assign mvd_o.mvp_idx = mvp_idx_q;
    assign mvd_o.x       = mvd_x_q;
    assign mvd_o.y       = mvd_y_q;

endmodule

`default_nettype wire

// File: verilog/mvd_top.sv
/* MVD stage for one 64x64 LCU per req/ack handshake. The MV memory answers a
   read one cycle after mv_rd_o.en, and every mvd_o.valid must be taken. */
`default_nettype none

`include "mvd_settings.svh"

module mvd_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    start_req_i,
    input  wire logic [`MVD_PART_W-1:0]  part_i,
    output wire logic                    done_ack_o,
    output wire mvd_pkg::mv_rd_t         mv_rd_o,
    input  wire mvd_pkg::mv_t            mv_rdata_i,
    output wire mvd_pkg::mvd_out_t       mvd_o
);
    import mvd_pkg::*;

    cu_info_t                   cu_info;
    logic                       cu_go;
    logic                       cu_end;
    pu_phase_e                  phase;
    logic                       pu_idx;
    nb_avail_t                  avail;
    logic [`MVD_BLK_ADDR_W-1:0] pu_addr;

    mvd_lcu_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_req_i (start_req_i),
        .part_i      (part_i),
        .cu_end_i    (cu_end),
        .cu_info_o   (cu_info),
        .cu_go_o     (cu_go),
        .done_ack_o  (done_ack_o)
    );

    mvd_pu_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .cu_go_i   (cu_go),
        .cu_info_i (cu_info),
        .phase_o   (phase),
        .pu_idx_o  (pu_idx),
        .cu_end_o  (cu_end)
    );

    mvd_pu_geom u_geom (
        .clk       (clk),
        .rst_n     (rst_n),
        .cu_info_i (cu_info),
        .phase_i   (phase),
        .pu_idx_i  (pu_idx),
        .mv_rd_o   (mv_rd_o),
        .avail_o   (avail),
        .pu_addr_o (pu_addr)
    );

    mvd_pred_sel u_sel (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase_i    (phase),
        .avail_i    (avail),
        .pu_addr_i  (pu_addr),
        .mv_rdata_i (mv_rdata_i),
        .mvd_o      (mvd_o)
    );

endmodule

`default_nettype wire

// File: tests/mvd_chk.sv
/* Handshake and read port properties of mvd_top, attached by bind.
   All properties are off while rst_n is low. */
`default_nettype none

module mvd_chk (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire logic              start_req_i,
    input wire logic              done_ack_o,
    input wire mvd_pkg::mv_rd_t   mv_rd_o,
    input wire mvd_pkg::mvd_out_t mvd_o
);
    timeunit 1ns;
    timeprecision 100ps;

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done_ack_o) |-> start_req_i)
        else $error("done_ack_o rose while start_req_i was low");

    // no memory traffic once the LCU is finished
    no_read_in_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !(mv_rd_o.en && done_ack_o))
        else $error("mv_rd_o.en high while done_ack_o is high");

    last_out_early: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done_ack_o) |-> ##2 !mvd_o.valid)
        else $error("mvd_o.valid high two cycles after done_ack_o rose");

endmodule

bind mvd_top mvd_chk chk0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_req_i (start_req_i),
    .done_ack_o  (done_ack_o),
    .mv_rd_o     (mv_rd_o),
    .mvd_o       (mvd_o)
);

`default_nettype wire

// File: tests/mvd_tb.sv
/* Self-checking testbench for mvd_top. The MV memory model answers one cycle after a
   read, and outputs are sampled on the falling edge, half a cycle after they change. */
`default_nettype none

`include "mvd_settings.svh"

module mvd_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mvd_pkg::*;

    localparam int TIMEOUT = 2000;  // cycles allowed per wait

    logic                   clk;
    logic                   rst_n;
    logic                   start_req_i;
    logic [`MVD_PART_W-1:0] part_i;
    logic                   done_ack_o;
    mv_rd_t                 mv_rd_o;
    mv_t                    mv_rdata_i;
    mvd_out_t               mvd_o;

    mv_t      mem [0:63];  // indexed by {y, x} of the 8x8 block
    mv_t      diag [0:14];
    mvd_out_t exp_q [$];
    mvd_out_t exp_rec;
    string    test_name;
    integer   seed;
    int       err_cnt;
    int       got_cnt;
    int       test_cnt;
    int       err_mark;
    int       got_mark;
    bit       hung;

    mvd_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_req_i (start_req_i),
        .part_i      (part_i),
        .done_ack_o  (done_ack_o),
        .mv_rd_o     (mv_rd_o),
        .mv_rdata_i  (mv_rdata_i),
        .mvd_o       (mvd_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (mv_rd_o.en) mv_rdata_i <= mem[mv_rd_o.addr];  // one cycle read latency
    end

    // bits needed for one MVD component, 1 for zero
    function automatic int bit_cost(input int d);
        int mag;
        int len;
        mag = (d < 0) ? -d : d;
        len = 0;
        while (mag > 0) begin
            len++;
            mag = mag >> 1;
        end
        if (len == 0) return 1;
        return 2 * len + 1;
    endfunction

    // expected record of the PU whose top-left block is (x, y)
    function automatic mvd_out_t predict_pu(input int x, input int y);
        mvd_out_t r;
        int       cx, cy, ax, ay, bx, by, px, py;
        bit       a_ok, b_ok, two;
        int       cost0, cost1;
        cx   = $signed(mem[y * 8 + x].x);
        cy   = $signed(mem[y * 8 + x].y);
        a_ok = (x > 0);
        b_ok = (y > 0);
        ax   = a_ok ? $signed(mem[y * 8 + x - 1].x) : 0;
        ay   = a_ok ? $signed(mem[y * 8 + x - 1].y) : 0;
        bx   = b_ok ? $signed(mem[(y - 1) * 8 + x].x) : 0;
        by   = b_ok ? $signed(mem[(y - 1) * 8 + x].y) : 0;
        px   = a_ok ? ax : bx;  // zero when neither neighbour exists
        py   = a_ok ? ay : by;
        two  = a_ok && b_ok && (ax != bx || ay != by);
        cost0 = bit_cost(cx - px) + bit_cost(cy - py);
        cost1 = bit_cost(cx - bx) + bit_cost(cy - by);
        r.valid   = 1'b1;
        r.addr    = `MVD_BLK_ADDR_W'(y * 8 + x);
        r.mvp_idx = two && (cost1 < cost0);
        r.x       = `MVD_MVD_W'(r.mvp_idx ? cx - bx : cx - px);
        r.y       = `MVD_MVD_W'(r.mvp_idx ? cy - by : cy - py);
        return r;
    endfunction

    function automatic part_e part_of(input logic [`MVD_PART_W-1:0] w, input int idx);
        return part_e'(w[2 * idx +: 2]);
    endfunction

    function automatic logic [`MVD_PART_W-1:0] set_part(input logic [`MVD_PART_W-1:0] w,
                                                         input int idx, input part_e p);
        logic [`MVD_PART_W-1:0] r;
        r = w;
        r[2 * idx +: 2] = p;
        return r;
    endfunction

    // size in 8x8 blocks
    function automatic void queue_cu(input part_e p, input int x, input int y, input int size);
        exp_q.push_back(predict_pu(x, y));
        if (p == PART_2NXN) exp_q.push_back(predict_pu(x, y + size / 2));
        if (p == PART_NX2N) exp_q.push_back(predict_pu(x + size / 2, y));
    endfunction

    function automatic void queue_lcu(input logic [`MVD_PART_W-1:0] w);
        int k1, k2, k3, c1, c2, x1, y1, x2, y2;
        if (part_of(w, 0) != PART_SPLIT) begin
            queue_cu(part_of(w, 0), 0, 0, 8);
            return;
        end
        for (k1 = 0; k1 < 4; k1++) begin
            c1 = 1 + k1;
            x1 = (k1 % 2) * 4;
            y1 = (k1 / 2) * 4;
            if (part_of(w, c1) != PART_SPLIT) begin
                queue_cu(part_of(w, c1), x1, y1, 4);
            end else begin
                for (k2 = 0; k2 < 4; k2++) begin
                    c2 = 4 * c1 + 1 + k2;
                    x2 = x1 + (k2 % 2) * 2;
                    y2 = y1 + (k2 / 2) * 2;
                    if (part_of(w, c2) != PART_SPLIT) begin
                        queue_cu(part_of(w, c2), x2, y2, 2);
                    end else begin
                        for (k3 = 0; k3 < 4; k3++) queue_cu(PART_2NX2N, x2 + k3 % 2, y2 + k3 / 2, 1);
                    end
                end
            end
        end
    endfunction

    task automatic check_field(input string field, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            err_cnt++;
            $display("[ERROR] %s: %s expected %0d actual %0d", test_name, field, exp_v, act_v);
        end
    endtask

    task automatic stall(input string what);
        err_cnt++;
        hung = 1'b1;
        $display("%s: timed out, %s", test_name, what);
    endtask

    always @(negedge clk) begin
        if (rst_n && mvd_o.valid) begin
            got_cnt++;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("%s: output at block %0d arrived when none was expected",
                         test_name, mvd_o.addr);
            end else begin
                exp_rec = exp_q.pop_front();
                check_field("addr", exp_rec.addr, mvd_o.addr);
                check_field("mvp_idx", exp_rec.mvp_idx, mvd_o.mvp_idx);
                check_field("mvd_x", $signed(exp_rec.x), $signed(mvd_o.x));
                check_field("mvd_y", $signed(exp_rec.y), $signed(mvd_o.y));
            end
        end
    end

    // one LCU through the req/ack handshake; hold keeps req high after ack
    task automatic run_lcu(input logic [`MVD_PART_W-1:0] w, input int hold);
        int n_exp;
        int got0;
        int cyc;
        int i;
        if (hung) return;
        queue_lcu(w);
        n_exp = exp_q.size();
        got0  = got_cnt;
        @(posedge clk);
        part_i      <= w;
        start_req_i <= 1'b1;
        cyc = 0;
        @(negedge clk);
        while (!done_ack_o && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!done_ack_o) begin
            stall("done_ack_o never rose");
            return;
        end
        cyc = 0;
        while (exp_q.size() != 0 && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("%s: %0d expected outputs never arrived", test_name, exp_q.size());
            exp_q.delete();
        end
        for (i = 0; i < hold; i++) begin
            @(negedge clk);
            if (!done_ack_o) begin
                err_cnt++;
                $display("%s: done_ack_o fell while start_req_i was still high", test_name);
            end
        end
        @(posedge clk);
        start_req_i <= 1'b0;
        cyc = 0;
        @(negedge clk);
        while (done_ack_o && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (done_ack_o) begin
            stall("done_ack_o stayed high after start_req_i fell");
            return;
        end
        check_field("output count", n_exp, got_cnt - got0);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = err_cnt;
        got_mark  = got_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        $display("%s finished: %0d outputs, %0d errors", test_name, got_cnt - got_mark,
                 err_cnt - err_mark);
    endtask

    task automatic fill_random();
        int i;
        for (i = 0; i < 64; i++) begin
            mem[i].x = `MVD_MV_W'($random(seed));
            mem[i].y = `MVD_MV_W'($random(seed));
        end
    endtask

    initial begin : main
        logic [`MVD_PART_W-1:0] pw;
        int                     i;
        clk = 1'b0;
        rst_n = 1'b0;
        start_req_i = 1'b0;
        part_i = '0;
        mv_rdata_i = '0;
        seed = 56;
        err_cnt = 0;
        got_cnt = 0;
        test_cnt = 0;
        hung = 1'b0;
        test_name = "reset";
        fill_random();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (done_ack_o || mv_rd_o.en || mvd_o.valid) begin
            err_cnt++;
            $display("reset: done_ack_o, mv_rd_o.en or mvd_o.valid is high after reset");
        end

        begin_test("unsplit_64x64");
        run_lcu('0, 0);
        end_test();

        begin_test("full_split_8x8");
        run_lcu({21{PART_SPLIT}}, 0);
        end_test();

        begin_test("mixed_partitions");
        run_lcu(set_part('0, 0, PART_2NXN), 0);
        run_lcu(set_part('0, 0, PART_NX2N), 0);
        pw = set_part('0, 0, PART_SPLIT);
        pw = set_part(pw, 1, PART_2NXN);
        pw = set_part(pw, 2, PART_NX2N);
        pw = set_part(pw, 3, PART_SPLIT);
        pw = set_part(pw, 13, PART_2NXN);  // children of cu 3 are 13..16
        pw = set_part(pw, 14, PART_NX2N);
        pw = set_part(pw, 16, PART_SPLIT);
        run_lcu(pw, 0);
        end_test();

        begin_test("equal_neighbours");
        for (i = 0; i < 15; i++) begin
            diag[i].x = `MVD_MV_W'($random(seed));
            diag[i].y = `MVD_MV_W'($random(seed));
        end
        // left and above of any block lie on the same anti-diagonal
        for (i = 0; i < 64; i++) mem[i] = diag[i / 8 + i % 8];
        run_lcu({21{PART_SPLIT}}, 0);
        end_test();

        begin_test("handshake");
        fill_random();
        run_lcu(pw, 12);
        repeat (20) @(negedge clk);
        for (i = 0; i < 21; i++) pw = set_part(pw, i, part_e'(2'($random(seed))));
        run_lcu(pw, 3);
        end_test();

        $display("tests run %0d, outputs seen %0d, errors %0d", test_cnt, got_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/mvd_pkg.sv
verilog/mvd_lcu_fsm.sv
verilog/mvd_pu_timer.sv
verilog/mvd_pu_geom.sv
verilog/mvd_pred_sel.sv
verilog/mvd_top.sv
tests/mvd_chk.sv
tests/mvd_tb.sv
